//--- compile.f
+incdir+rtl
rtl/nbody_body_pkg.sv
rtl/nbody_bus_pkg.sv
rtl/body_ram.sv
rtl/body_store.sv
rtl/nbody_csr.sv
rtl/sweep_sequencer.sv
rtl/pos_update_pipe.sv
rtl/nbody_top.sv
testbench/nbody_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= nbody_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/nbody_tb.sv
`timescale 1ns/1ps
`include "nbody_defines.svh"

module nbody_tb;

    localparam int N_ROWS = 5;
    localparam int LAT    = `NBODY_UPD_LAT;
    localparam int NB     = `NBODY_BODIES;

    typedef struct packed {
        logic [`NBODY_BODY_W:0]      num_bodies;
        nbody_body_pkg::step_count_t gap;
        logic                        abort;
    } test_row_t;

    logic                     clk;
    logic                     rst;
    logic                     chipselect;
    logic                     read_en;
    logic                     write_en;
    logic [`NBODY_ADDR_W-1:0] addr;
    nbody_bus_pkg::ext_word_t writedata;
    nbody_bus_pkg::ext_word_t readdata;

    test_row_t              rows [N_ROWS];
    nbody_body_pkg::coord_t ref_x [NB];
    nbody_body_pkg::coord_t ref_y [NB];
    nbody_body_pkg::coord_t ref_vx [NB];
    nbody_body_pkg::coord_t ref_vy [NB];
    logic [31:0]            lfsr_q = 32'haaa3;
    int                     cycle_count = 0;
    int                     cycle_limit;

    nbody_top i_dut (
        .clk(clk), .rst(rst), .chipselect_i(chipselect), .read_i(read_en),
        .write_i(write_en), .addr_i(addr), .writedata_i(writedata), .readdata_o(readdata)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run took more than %0d clock cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_coord(output nbody_body_pkg::coord_t v);
        int i;
        v = '0;
        for (i = 0; i < `NBODY_DATA_W; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[`NBODY_DATA_W-2:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [`NBODY_ADDR_W-1:0] make_addr(
        input logic [`NBODY_SEL_W-1:0] sel, input nbody_body_pkg::body_idx_t body);
        logic [`NBODY_ADDR_W-1:0] a;
        a = '0;
        a[`NBODY_ADDR_W-1:`NBODY_SEL_LSB] = sel;
        a[`NBODY_BODY_W-1:0] = body;
        return a;
    endfunction

    // Upper bound on one run in cycles, GAP of zero runs once
    function automatic int run_length(input test_row_t r);
        int g;
        g = (int'(r.gap) == 0) ? 1 : int'(r.gap);
        return g * (int'(r.num_bodies) + LAT + 3);
    endfunction

    task automatic check_word(input string name, input nbody_bus_pkg::ext_word_t exp,
                              input nbody_bus_pkg::ext_word_t act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "bus word mismatch");
        end
    endtask

    task automatic check_coord(input string name, input nbody_body_pkg::coord_t exp,
                               input nbody_body_pkg::coord_t act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "position mismatch");
        end
    endtask

    task automatic bus_write(input logic [`NBODY_SEL_W-1:0] sel,
                             input nbody_body_pkg::body_idx_t body,
                             input nbody_bus_pkg::ext_word_t data);
        @(posedge clk);
        chipselect <= 1'b1;
        write_en   <= 1'b1;
        addr       <= make_addr(sel, body);
        writedata  <= data;
        @(posedge clk);
        chipselect <= 1'b0;
        write_en   <= 1'b0;
    endtask

    // Word comes back in the cycle after the strobe
    task automatic bus_read(input logic [`NBODY_SEL_W-1:0] sel,
                            input nbody_body_pkg::body_idx_t body,
                            output nbody_bus_pkg::ext_word_t word);
        @(posedge clk);
        chipselect <= 1'b1;
        read_en    <= 1'b1;
        addr       <= make_addr(sel, body);
        @(posedge clk);
        chipselect <= 1'b0;
        read_en    <= 1'b0;
        @(negedge clk);
        word = readdata;
    endtask

    task automatic write_coord(input logic [`NBODY_SEL_W-1:0] lo_sel,
                               input logic [`NBODY_SEL_W-1:0] hi_sel,
                               input nbody_body_pkg::body_idx_t body,
                               input nbody_body_pkg::coord_t v);
        bus_write(lo_sel, body, v[`NBODY_EXT_W-1:0]);
        bus_write(hi_sel, body, v[`NBODY_DATA_W-1:`NBODY_EXT_W]);
    endtask

    task automatic load_bodies();
        int i;
        nbody_body_pkg::body_idx_t b;
        for (i = 0; i < NB; i++) begin
            b = nbody_body_pkg::body_idx_t'(i);
            draw_coord(ref_x[i]);
            draw_coord(ref_y[i]);
            draw_coord(ref_vx[i]);
            draw_coord(ref_vy[i]);
            write_coord(nbody_bus_pkg::X_LO, nbody_bus_pkg::X_HI, b, ref_x[i]);
            write_coord(nbody_bus_pkg::Y_LO, nbody_bus_pkg::Y_HI, b, ref_y[i]);
            write_coord(nbody_bus_pkg::VX_LO, nbody_bus_pkg::VX_HI, b, ref_vx[i]);
            write_coord(nbody_bus_pkg::VY_LO, nbody_bus_pkg::VY_HI, b, ref_vy[i]);
        end
    endtask

    // All bodies, so untouched ones are covered too
    task automatic check_positions();
        int i;
        nbody_body_pkg::body_idx_t b;
        nbody_bus_pkg::ext_word_t  lo;
        nbody_bus_pkg::ext_word_t  hi;
        for (i = 0; i < NB; i++) begin
            b = nbody_body_pkg::body_idx_t'(i);
            bus_read(nbody_bus_pkg::RD_X_LO, b, lo);
            bus_read(nbody_bus_pkg::RD_X_HI, b, hi);
            check_coord($sformatf("x[%0d]", i), ref_x[i], {hi, lo});
            bus_read(nbody_bus_pkg::RD_Y_LO, b, lo);
            bus_read(nbody_bus_pkg::RD_Y_HI, b, hi);
            check_coord($sformatf("y[%0d]", i), ref_y[i], {hi, lo});
        end
    endtask

    // READ=1 with go high clears done, READ=0 then launches the run
    task automatic start_run(input test_row_t r);
        nbody_bus_pkg::ext_word_t w;
        bus_write(nbody_bus_pkg::N_BODIES, '0, nbody_bus_pkg::ext_word_t'(r.num_bodies));
        bus_write(nbody_bus_pkg::GAP, '0, nbody_bus_pkg::ext_word_t'(r.gap));
        bus_write(nbody_bus_pkg::READ, '0, 32'd1);
        bus_write(nbody_bus_pkg::GO, '0, 32'd1);
        bus_read(nbody_bus_pkg::DONE, '0, w);
        check_word("DONE after READ=1", 32'd0, w);
        bus_write(nbody_bus_pkg::READ, '0, 32'd0);
    endtask

    task automatic wait_done();
        nbody_bus_pkg::ext_word_t w;
        do begin
            bus_read(nbody_bus_pkg::DONE, '0, w);
            if (w !== 32'd1) begin
                check_word("DONE while running", 32'd0, w);
            end
        end while (w !== 32'd1);
    endtask

    task automatic apply_sweeps(input test_row_t r);
        int i;
        int g;
        g = (int'(r.gap) == 0) ? 1 : int'(r.gap);
        for (i = 0; i < int'(r.num_bodies); i++) begin
            ref_x[i] = ref_x[i] + nbody_body_pkg::coord_t'(g) * ref_vx[i];
            ref_y[i] = ref_y[i] + nbody_body_pkg::coord_t'(g) * ref_vy[i];
        end
    endtask

    initial begin
        int r;
        int accesses;
        int run_cycles;
        nbody_bus_pkg::ext_word_t w;

        rows[0] = '{num_bodies: 5'd16, gap: 16'd3, abort: 1'b0};
        rows[1] = '{num_bodies: 5'd5, gap: 16'd1, abort: 1'b1};
        rows[2] = '{num_bodies: 5'd1, gap: 16'd0, abort: 1'b0};
        rows[3] = '{num_bodies: 5'd11, gap: 16'd7, abort: 1'b1};
        rows[4] = '{num_bodies: 5'd16, gap: 16'd2, abort: 1'b0};

        // Abort rows load once more and idle for one run length
        accesses   = 2;
        run_cycles = 3;
        for (r = 0; r < N_ROWS; r++) begin
            run_cycles += 2 * run_length(rows[r]);
            accesses   += NB * 8 + NB * 4 + 2 * (6 + NB * 4);
            if (rows[r].abort) begin
                run_cycles += run_length(rows[r]);
                accesses   += NB * 8 + 8;
            end
        end
        cycle_limit = 2 * (run_cycles + 40 * accesses);

        rst        <= 1'b1;
        chipselect <= 1'b0;
        read_en    <= 1'b0;
        write_en   <= 1'b0;
        addr       <= '0;
        writedata  <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        bus_read(nbody_bus_pkg::DONE, '0, w);
        check_word("DONE after reset", 32'd0, w);
        bus_read(7'h00, '0, w);
        check_word("unmapped select", '1, w);

        for (r = 0; r < N_ROWS; r++) begin
            if (rows[r].abort) begin
                load_bodies();
                start_run(rows[r]);
                bus_write(nbody_bus_pkg::GO, '0, 32'd0);
                // Past the point where a full run would have raised done
                repeat (run_length(rows[r])) @(posedge clk);
                bus_read(nbody_bus_pkg::DONE, '0, w);
                check_word("DONE after abort", 32'd0, w);
            end
            load_bodies();
            check_positions();
            start_run(rows[r]);
            wait_done();
            apply_sweeps(rows[r]);
            check_positions();
            // Second run continues from the updated positions
            start_run(rows[r]);
            wait_done();
            apply_sweeps(rows[r]);
            check_positions();
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- rtl/nbody_top.sv
`timescale 1ns/1ps
`include "nbody_defines.svh"

module nbody_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     chipselect_i,
    input  logic                     read_i,
    input  logic                     write_i,
    input  logic [`NBODY_ADDR_W-1:0] addr_i,
    input  nbody_bus_pkg::ext_word_t writedata_i,
    output nbody_bus_pkg::ext_word_t readdata_o
);

    nbody_bus_pkg::ctrl_t      ctrl;
    nbody_bus_pkg::sw_write_t  sw_wr;
    nbody_body_pkg::body_idx_t rb_body;
    nbody_body_pkg::coord_t    rb_x;
    nbody_body_pkg::coord_t    rb_y;
    nbody_body_pkg::upd_req_t  upd_req;
    nbody_body_pkg::body_rd_t  body_rd;
    nbody_body_pkg::upd_wr_t   upd_wr;
    logic                      running;
    logic                      done;

    nbody_csr i_csr (
        .clk, .rst, .chipselect_i, .read_i, .write_i, .addr_i, .writedata_i,
        .done_i(done), .rb_x_i(rb_x), .rb_y_i(rb_y),
        .ctrl_o(ctrl), .sw_wr_o(sw_wr), .rb_body_o(rb_body), .readdata_o
    );

    sweep_sequencer i_seq (
        .clk, .rst, .ctrl_i(ctrl), .wr_seen_i(upd_wr),
        .upd_req_o(upd_req), .running_o(running), .done_o(done)
    );

    body_store i_store (
        .clk, .rst, .running_i(running), .sw_wr_i(sw_wr), .rb_body_i(rb_body),
        .upd_req_i(upd_req), .upd_wr_i(upd_wr),
        .body_rd_o(body_rd), .rb_x_o(rb_x), .rb_y_o(rb_y)
    );

    pos_update_pipe i_pipe (
        .clk, .rst, .req_i(upd_req), .body_rd_i(body_rd), .upd_wr_o(upd_wr)
    );

endmodule

//--- rtl/pos_update_pipe.sv
`timescale 1ns/1ps
`include "nbody_defines.svh"

module pos_update_pipe (
    input  logic                     clk,
    input  logic                     rst,
    input  nbody_body_pkg::upd_req_t req_i,
    input  nbody_body_pkg::body_rd_t body_rd_i,
    output nbody_body_pkg::upd_wr_t  upd_wr_o
);

    localparam int LAT = `NBODY_UPD_LAT;

    logic                      req_vld_q;
    nbody_body_pkg::body_idx_t req_body_q;
    logic [LAT-1:0]            vld_q;
    nbody_body_pkg::body_idx_t body_q [LAT];
    nbody_body_pkg::coord_t    x_q [LAT];
    nbody_body_pkg::coord_t    y_q [LAT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_vld_q <= 1'b0;
            vld_q     <= '0;
        end else begin
            req_vld_q <= req_i.valid;
            vld_q     <= {vld_q[LAT-2:0], req_vld_q};
        end
    end

    // Request lines up with the memory output one cycle later
    always_ff @(posedge clk) begin
        req_body_q <= req_i.body;
        body_q[0]  <= req_body_q;
        x_q[0]     <= body_rd_i.x + body_rd_i.vx;
        y_q[0]     <= body_rd_i.y + body_rd_i.vy;
        for (int s = 1; s < LAT; s++) begin
            body_q[s] <= body_q[s-1];
            x_q[s]    <= x_q[s-1];
            y_q[s]    <= y_q[s-1];
        end
    end

    assign upd_wr_o = '{valid: vld_q[LAT-1], body: body_q[LAT-1],
                        x: x_q[LAT-1], y: y_q[LAT-1]};

    a_fixed_latency: assert property (@(posedge clk) disable iff (rst)
        upd_wr_o.valid == $past(req_i.valid, LAT + 1));

endmodule

//--- rtl/sweep_sequencer.sv
`timescale 1ns/1ps

module sweep_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  nbody_bus_pkg::ctrl_t     ctrl_i,
    input  nbody_body_pkg::upd_wr_t  wr_seen_i,
    output nbody_body_pkg::upd_req_t upd_req_o,
    output logic                     running_o,
    output logic                     done_o
);

    nbody_body_pkg::sweep_state_e state_q;
    nbody_body_pkg::body_idx_t    idx_q;
    nbody_body_pkg::step_count_t  gap_cnt_q;
    logic                         issue_q;
    logic                         done_q;
    logic                         last_issue;
    logic                         last_write;
    logic                         last_sweep;

    assign last_issue = {1'b0, idx_q} == ctrl_i.num_bodies - 1'b1;
    assign last_write = wr_seen_i.valid && ({1'b0, wr_seen_i.body} == ctrl_i.num_bodies - 1'b1);
    // GAP of zero still runs one sweep
    assign last_sweep = (gap_cnt_q + 1'b1) >= ctrl_i.gap;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= nbody_body_pkg::IDLE;
            idx_q     <= '0;
            gap_cnt_q <= '0;
            issue_q   <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            case (state_q)
                nbody_body_pkg::IDLE: begin
                    if (ctrl_i.go) begin
                        if (ctrl_i.read_sw) begin
                            done_q <= 1'b0;
                        end else if (!done_q) begin
                            if (ctrl_i.num_bodies == '0) begin
                                // Nothing to move
                                done_q <= 1'b1;
                            end else begin
                                state_q   <= nbody_body_pkg::UPDATE_POS;
                                idx_q     <= '0;
                                gap_cnt_q <= '0;
                                issue_q   <= 1'b1;
                            end
                        end
                    end
                end
                nbody_body_pkg::UPDATE_POS: begin
                    if (!ctrl_i.go) begin
                        state_q <= nbody_body_pkg::IDLE;
                        issue_q <= 1'b0;
                    end else begin
                        if (issue_q) begin
                            if (last_issue) begin
                                issue_q <= 1'b0;
                            end else begin
                                idx_q <= idx_q + 1'b1;
                            end
                        end
                        // Sweep ends when its last body lands in memory
                        if (last_write) begin
                            if (last_sweep) begin
                                state_q <= nbody_body_pkg::IDLE;
                                done_q  <= 1'b1;
                            end else begin
                                gap_cnt_q <= gap_cnt_q + 1'b1;
                                idx_q     <= '0;
                                issue_q   <= 1'b1;
                            end
                        end
                    end
                end
                default: state_q <= nbody_body_pkg::IDLE;
            endcase
        end
    end

    assign upd_req_o = '{valid: issue_q, body: idx_q};
    assign running_o = state_q == nbody_body_pkg::UPDATE_POS;
    assign done_o    = done_q;

    a_done_not_running: assert property (@(posedge clk) disable iff (rst)
        !(done_o && running_o));

    a_idx_in_range: assert property (@(posedge clk) disable iff (rst)
        upd_req_o.valid |-> ({1'b0, upd_req_o.body} < ctrl_i.num_bodies));

endmodule

//--- rtl/nbody_csr.sv
`timescale 1ns/1ps
`include "nbody_defines.svh"

module nbody_csr (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      chipselect_i,
    input  logic                      read_i,
    input  logic                      write_i,
    input  logic [`NBODY_ADDR_W-1:0]  addr_i,
    input  nbody_bus_pkg::ext_word_t  writedata_i,
    input  logic                      done_i,
    input  nbody_body_pkg::coord_t    rb_x_i,
    input  nbody_body_pkg::coord_t    rb_y_i,
    output nbody_bus_pkg::ctrl_t      ctrl_o,
    output nbody_bus_pkg::sw_write_t  sw_wr_o,
    output nbody_body_pkg::body_idx_t rb_body_o,
    output nbody_bus_pkg::ext_word_t  readdata_o
);

    logic                        wr_en;
    logic                        rd_en;
    logic [`NBODY_SEL_W-1:0]     sel;
    nbody_body_pkg::body_idx_t   addr_body;
    logic                        go_q;
    logic                        read_q;
    logic [`NBODY_BODY_W:0]      num_q;
    nbody_body_pkg::step_count_t gap_q;
    logic [3:0]                  stb_q;
    logic [`NBODY_SEL_W-1:0]     rd_sel_q;
    nbody_body_pkg::body_idx_t   rb_body_q;
    nbody_bus_pkg::ext_word_t    lo_q;
    nbody_body_pkg::body_idx_t   wr_body_q;
    nbody_body_pkg::coord_t      wr_data_q;

    assign wr_en     = chipselect_i & write_i;
    assign rd_en     = chipselect_i & read_i;
    assign sel       = addr_i[`NBODY_ADDR_W-1:`NBODY_SEL_LSB];
    assign addr_body = addr_i[`NBODY_BODY_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            go_q      <= 1'b0;
            read_q    <= 1'b0;
            num_q     <= '0;
            gap_q     <= '0;
            stb_q     <= '0;
            rd_sel_q  <= '0;
            rb_body_q <= '0;
        end else begin
            stb_q <= '0;
            if (wr_en) begin
                case (sel)
                    nbody_bus_pkg::GO:       go_q   <= writedata_i[0];
                    nbody_bus_pkg::READ:     read_q <= writedata_i[0];
                    nbody_bus_pkg::N_BODIES: num_q  <= writedata_i[`NBODY_BODY_W:0];
                    nbody_bus_pkg::GAP:      gap_q  <= writedata_i[`NBODY_STEP_W-1:0];
                    nbody_bus_pkg::X_HI:     stb_q  <= 4'b1000;
                    nbody_bus_pkg::Y_HI:     stb_q  <= 4'b0100;
                    nbody_bus_pkg::VX_HI:    stb_q  <= 4'b0010;
                    nbody_bus_pkg::VY_HI:    stb_q  <= 4'b0001;
                    default: ;
                endcase
            end
            if (rd_en) begin
                rd_sel_q  <= sel;
                rb_body_q <= addr_body;
            end
        end
    end

    // Lower half waits here until its upper half arrives
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (sel)
                nbody_bus_pkg::X_LO, nbody_bus_pkg::Y_LO,
                nbody_bus_pkg::VX_LO, nbody_bus_pkg::VY_LO: lo_q <= writedata_i;
                default: ;
            endcase
            wr_body_q <= addr_body;
            wr_data_q <= {writedata_i, lo_q};
        end
    end

    assign ctrl_o  = '{go: go_q, read_sw: read_q, num_bodies: num_q, gap: gap_q};
    assign sw_wr_o = '{wr_x: stb_q[3], wr_y: stb_q[2], wr_vx: stb_q[1], wr_vy: stb_q[0],
                       body: wr_body_q, data: wr_data_q};

    // Address the memory in the read cycle, hold it afterwards
    assign rb_body_o = rd_en ? addr_body : rb_body_q;

    always_comb begin
        case (rd_sel_q)
            nbody_bus_pkg::DONE:    readdata_o = {{(`NBODY_EXT_W-1){1'b0}}, done_i};
            nbody_bus_pkg::RD_X_LO: readdata_o = rb_x_i[`NBODY_EXT_W-1:0];
            nbody_bus_pkg::RD_X_HI: readdata_o = rb_x_i[`NBODY_DATA_W-1:`NBODY_EXT_W];
            nbody_bus_pkg::RD_Y_LO: readdata_o = rb_y_i[`NBODY_EXT_W-1:0];
            nbody_bus_pkg::RD_Y_HI: readdata_o = rb_y_i[`NBODY_DATA_W-1:`NBODY_EXT_W];
            default:                readdata_o = '1;
        endcase
    end

endmodule

//--- rtl/body_store.sv
`timescale 1ns/1ps
`include "nbody_defines.svh"

module body_store (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      running_i,
    input  nbody_bus_pkg::sw_write_t  sw_wr_i,
    input  nbody_body_pkg::body_idx_t rb_body_i,
    input  nbody_body_pkg::upd_req_t  upd_req_i,
    input  nbody_body_pkg::upd_wr_t   upd_wr_i,
    output nbody_body_pkg::body_rd_t  body_rd_o,
    output nbody_body_pkg::coord_t    rb_x_o,
    output nbody_body_pkg::coord_t    rb_y_o
);

    nbody_body_pkg::body_idx_t rd_addr;
    nbody_body_pkg::body_idx_t pos_waddr;
    nbody_body_pkg::coord_t    x_wdata;
    nbody_body_pkg::coord_t    y_wdata;
    logic                      x_we;
    logic                      y_we;
    logic                      vx_we;
    logic                      vy_we;
    logic                      sw_any;
    nbody_body_pkg::coord_t    x_q;
    nbody_body_pkg::coord_t    y_q;
    nbody_body_pkg::coord_t    vx_q;
    nbody_body_pkg::coord_t    vy_q;

    assign sw_any = sw_wr_i.wr_x | sw_wr_i.wr_y | sw_wr_i.wr_vx | sw_wr_i.wr_vy;

    // Sweep owns the ports while running, software otherwise
    assign rd_addr   = running_i ? upd_req_i.body : rb_body_i;
    assign pos_waddr = running_i ? upd_wr_i.body : sw_wr_i.body;
    assign x_wdata   = running_i ? upd_wr_i.x : sw_wr_i.data;
    assign y_wdata   = running_i ? upd_wr_i.y : sw_wr_i.data;
    assign x_we      = running_i ? upd_wr_i.valid : sw_wr_i.wr_x;
    assign y_we      = running_i ? upd_wr_i.valid : sw_wr_i.wr_y;

    // Velocities only change from software
    assign vx_we = sw_wr_i.wr_vx & ~running_i;
    assign vy_we = sw_wr_i.wr_vy & ~running_i;

    body_ram i_x_ram  (.clk, .we_i(x_we),  .waddr_i(pos_waddr),    .wdata_i(x_wdata),
                       .raddr_i(rd_addr), .rdata_o(x_q));
    body_ram i_y_ram  (.clk, .we_i(y_we),  .waddr_i(pos_waddr),    .wdata_i(y_wdata),
                       .raddr_i(rd_addr), .rdata_o(y_q));
    body_ram i_vx_ram (.clk, .we_i(vx_we), .waddr_i(sw_wr_i.body), .wdata_i(sw_wr_i.data),
                       .raddr_i(rd_addr), .rdata_o(vx_q));
    body_ram i_vy_ram (.clk, .we_i(vy_we), .waddr_i(sw_wr_i.body), .wdata_i(sw_wr_i.data),
                       .raddr_i(rd_addr), .rdata_o(vy_q));

    assign body_rd_o = '{x: x_q, y: y_q, vx: vx_q, vy: vy_q};
    assign rb_x_o    = x_q;
    assign rb_y_o    = y_q;

    // Software never strobes a memory during write-back of a sweep
    a_no_sw_during_update: assert property (@(posedge clk) disable iff (rst)
        (upd_wr_i.valid && running_i) |-> !sw_any);

endmodule

//--- rtl/body_ram.sv
`timescale 1ns/1ps
`include "nbody_defines.svh"

module body_ram #(
    parameter int DATA_W = `NBODY_DATA_W,
    parameter int DEPTH  = `NBODY_BODIES
) (
    input  logic                      clk,
    input  logic                      we_i,
    input  nbody_body_pkg::body_idx_t waddr_i,
    input  nbody_body_pkg::coord_t    wdata_i,
    input  nbody_body_pkg::body_idx_t raddr_i,
    output nbody_body_pkg::coord_t    rdata_o
);

    logic [DATA_W-1:0] mem [DEPTH];

    // Read before write on a shared address
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_o <= mem[raddr_i];
    end

endmodule

//--- rtl/nbody_bus_pkg.sv
`include "nbody_defines.svh"

package nbody_bus_pkg;

    // Register select, address bits above the body index
    typedef enum logic [`NBODY_SEL_W-1:0] {
        GO       = 7'h40,
        READ     = 7'h41,
        N_BODIES = 7'h42,
        GAP      = 7'h43,
        X_LO     = 7'h44,
        X_HI     = 7'h45,
        Y_LO     = 7'h46,
        Y_HI     = 7'h47,
        VX_LO    = 7'h4a,
        VX_HI    = 7'h4b,
        VY_LO    = 7'h4c,
        VY_HI    = 7'h4d,
        DONE     = 7'h50,
        RD_X_LO  = 7'h51,
        RD_X_HI  = 7'h52,
        RD_Y_LO  = 7'h53,
        RD_Y_HI  = 7'h54
    } reg_sel_e;

    typedef logic [`NBODY_EXT_W-1:0] ext_word_t;

    // Software write into one of the body memories
    typedef struct packed {
        logic                      wr_x;
        logic                      wr_y;
        logic                      wr_vx;
        logic                      wr_vy;
        nbody_body_pkg::body_idx_t body;
        nbody_body_pkg::coord_t    data;
    } sw_write_t;

    // Control registers seen by the sequencer
    typedef struct packed {
        logic                        go;
        logic                        read_sw;
        logic [`NBODY_BODY_W:0]      num_bodies;
        nbody_body_pkg::step_count_t gap;
    } ctrl_t;

endpackage

//--- rtl/nbody_body_pkg.sv
`include "nbody_defines.svh"

package nbody_body_pkg;

    typedef logic [`NBODY_BODY_W-1:0] body_idx_t;
    typedef logic [`NBODY_DATA_W-1:0] coord_t;
    typedef logic [`NBODY_STEP_W-1:0] step_count_t;

    typedef enum logic {
        IDLE,
        UPDATE_POS
    } sweep_state_e;

    // Body issued for a position update
    typedef struct packed {
        logic      valid;
        body_idx_t body;
    } upd_req_t;

    // One body as read from the four memories
    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t vx;
        coord_t vy;
    } body_rd_t;

    // Updated position on its way back to memory
    typedef struct packed {
        logic      valid;
        body_idx_t body;
        coord_t    x;
        coord_t    y;
    } upd_wr_t;

endpackage

//--- rtl/nbody_defines.svh
`ifndef NBODY_DEFINES_SVH
`define NBODY_DEFINES_SVH

// Body memory depth and index width
`define NBODY_BODIES 16
`define NBODY_BODY_W 4

// Coordinate and bus widths
`define NBODY_DATA_W 64
`define NBODY_EXT_W 32
`define NBODY_ADDR_W 16

// Register select sits above the body index
`define NBODY_SEL_LSB 9
`define NBODY_SEL_W 7

// Sweep counter width
`define NBODY_STEP_W 16

// Register stages in the position adder
`define NBODY_UPD_LAT 3

`endif
